/* core_params.svh */
// Core parameters
// Shared widths, fetch depth, reset PC and assertion bounds

`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Opaque tag width on both memory ports
`define CORE_OPAQ_BITS 8

// Max fetch requests in flight, also the fetch queue depth
`define CORE_FETCH_DEPTH 2

// First instruction address after reset
`define CORE_RESET_PC 32'h0000_0000

// Cycles allowed for a load or store to leave wait_mem
`define CORE_MEM_TIMEOUT 100

`endif

/* mem_pkg.sv */
// Memory types
// Address, data and tag types plus request and response messages

`default_nettype none

`include "core_params.svh"

package mem_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [`CORE_OPAQ_BITS-1:0] opaq_t;

  typedef enum logic {
    mem_read  = 1'b0,
    mem_write = 1'b1
  } mem_op_t;

  // Request message, 73 bits
  typedef struct packed {
    mem_op_t op;
    opaq_t   opaq;
    addr_t   addr;
    word_t   data;
  } mem_req_t;

  // Response message, 41 bits, tag echoed back
  typedef struct packed {
    mem_op_t op;
    opaq_t   opaq;
    word_t   data;
  } mem_resp_t;

endpackage

`default_nettype wire

/* core_pkg.sv */
// Core types
// Decoded instruction, fetch packet, redirect, trace record, execute FSM

`default_nettype none

package core_pkg;

  typedef logic [4:0] reg_idx_t;

  // Supported subset, anything else decodes to op_illegal
  typedef enum logic [2:0] {
    op_addi,
    op_add,
    op_lw,
    op_sw,
    op_bne,
    op_illegal
  } opcode_t;

  typedef struct packed {
    opcode_t        opcode;
    reg_idx_t       rd;
    reg_idx_t       rs1;
    reg_idx_t       rs2;
    mem_pkg::word_t imm;
  } inst_t;

  // Fetch to execute
  typedef struct packed {
    mem_pkg::addr_t pc;
    mem_pkg::word_t inst;
  } fetch_pkt_t;

  // Execute to fetch, one cycle pulse
  typedef struct packed {
    logic           val;
    mem_pkg::addr_t target;
  } redirect_t;

  // Retirement record, 70 bits
  typedef struct packed {
    mem_pkg::addr_t pc;
    reg_idx_t       waddr;
    mem_pkg::word_t wdata;
    logic           wen;
  } inst_trace_t;

  typedef enum logic [1:0] {
    st_idle,
    st_wait_mem,
    st_retire
  } exec_state_t;

endpackage

`default_nettype wire

/* fetch_unit.sv */
// Fetch unit
// Issues instruction reads, tags them with an epoch and slot, drops
// wrong-path responses and queues fetched words for execute

`default_nettype none

`include "core_params.svh"

module fetch_unit (
  input  logic                 clk,
  input  logic                 reset,
  output mem_pkg::mem_req_t    imem_req,
  output logic                 imem_req_val,
  input  logic                 imem_req_rdy,
  input  mem_pkg::mem_resp_t   imem_resp,
  input  logic                 imem_resp_val,
  output logic                 imem_resp_rdy,
  input  core_pkg::redirect_t  redirect,
  output core_pkg::fetch_pkt_t pkt,
  output logic                 pkt_val,
  input  logic                 pkt_rdy
);

  // Tag layout is {epoch, slot}
  localparam int slot_bits  = $clog2(`CORE_FETCH_DEPTH);
  localparam int epoch_bits = `CORE_OPAQ_BITS - slot_bits;
  localparam int cnt_bits   = $clog2(`CORE_FETCH_DEPTH + 1);

  mem_pkg::addr_t        pc;
  logic [epoch_bits-1:0] epoch;
  logic [slot_bits-1:0]  issue_slot;
  logic [cnt_bits-1:0]   inflight;
  logic [cnt_bits:0]     occupancy;

  // PC of each outstanding request, indexed by slot
  mem_pkg::addr_t        slot_pc [`CORE_FETCH_DEPTH];

  core_pkg::fetch_pkt_t  q_mem [`CORE_FETCH_DEPTH];
  logic [slot_bits-1:0]  q_head;
  logic [slot_bits-1:0]  q_tail;
  logic [cnt_bits-1:0]   q_count;

  logic                  issue;
  logic                  resp_fire;
  logic                  enq;
  logic                  deq;
  logic [slot_bits-1:0]  resp_slot;
  logic [epoch_bits-1:0] resp_epoch;

  // ----------------------------------------
  // Issue and response control
  // ----------------------------------------

  // Queue space is reserved for everything in flight
  assign occupancy = inflight + q_count;
  // No issue in a redirect cycle, the new PC goes out next cycle
  assign issue = (!imem_req_val || imem_req_rdy) && !redirect.val &&
                 (int'(occupancy) < `CORE_FETCH_DEPTH);

  // Room is always reserved, so responses never stall
  assign imem_resp_rdy = 1'b1;
  assign resp_fire     = imem_resp_val && imem_resp_rdy;
  assign resp_slot     = imem_resp.opaq[slot_bits-1:0];
  assign resp_epoch    = imem_resp.opaq[`CORE_OPAQ_BITS-1:slot_bits];

  // Stale epoch or same-cycle redirect means wrong path
  assign enq = resp_fire && (resp_epoch == epoch) && !redirect.val;
  assign deq = pkt_val && pkt_rdy;

  assign pkt     = q_mem[q_head];
  assign pkt_val = (q_count != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      pc           <= `CORE_RESET_PC;
      epoch        <= '0;
      issue_slot   <= '0;
      inflight     <= '0;
      imem_req_val <= 1'b0;
      q_head       <= '0;
      q_tail       <= '0;
      q_count      <= '0;
    end else begin
      // Held request stays valid until taken
      imem_req_val <= issue || (imem_req_val && !imem_req_rdy);
      inflight     <= inflight + cnt_bits'(issue) - cnt_bits'(resp_fire);
      if (issue) begin
        pc         <= pc + 32'd4;
        issue_slot <= issue_slot + 1'b1;
      end
      if (redirect.val) begin
        pc    <= redirect.target;
        epoch <= epoch + 1'b1;
        // Flush queued wrong-path words
        q_head  <= '0;
        q_tail  <= '0;
        q_count <= '0;
      end else begin
        if (enq)
          q_tail <= q_tail + 1'b1;
        if (deq)
          q_head <= q_head + 1'b1;
        q_count <= q_count + cnt_bits'(enq) - cnt_bits'(deq);
      end
    end
  end

  // Request payload and queue storage
  always_ff @(posedge clk) begin
    if (issue) begin
      imem_req <= '{op: mem_pkg::mem_read, opaq: {epoch, issue_slot}, addr: pc, data: '0};
      slot_pc[issue_slot] <= pc;
    end
    if (enq)
      q_mem[q_tail] <= '{pc: slot_pc[resp_slot], inst: imem_resp.data};
  end

  // ----------------------------------------
  // Assertions
  // ----------------------------------------

  a_inflight_max: assert property (@(posedge clk) disable iff (reset)
    int'(inflight) <= `CORE_FETCH_DEPTH)
    else $error("fetch: %0d requests in flight", inflight);

  a_req_stable: assert property (@(posedge clk) disable iff (reset)
    imem_req_val && !imem_req_rdy |=> imem_req_val && $stable(imem_req))
    else $error("fetch: imem request changed under back-pressure");

endmodule

`default_nettype wire

/* exec_unit.sv */
// Execute unit
// Decode, register file, ALU, load/store sequencing, branch resolution
// and one trace record per retired instruction

`default_nettype none

`include "core_params.svh"

module exec_unit (
  input  logic                  clk,
  input  logic                  reset,
  input  core_pkg::fetch_pkt_t  pkt,
  input  logic                  pkt_val,
  output logic                  pkt_rdy,
  output mem_pkg::mem_req_t     dmem_req,
  output logic                  dmem_req_val,
  input  logic                  dmem_req_rdy,
  input  mem_pkg::mem_resp_t    dmem_resp,
  input  logic                  dmem_resp_val,
  output logic                  dmem_resp_rdy,
  output core_pkg::redirect_t   redirect,
  output core_pkg::inst_trace_t trace,
  output logic                  trace_val
);

  core_pkg::exec_state_t state;
  core_pkg::inst_t       dec;
  core_pkg::inst_t       dec_q;
  mem_pkg::addr_t        pc_q;
  mem_pkg::word_t        rs1_val;
  mem_pkg::word_t        rs2_val;
  mem_pkg::word_t        rs1_q;
  mem_pkg::word_t        rs2_q;
  mem_pkg::word_t        ld_data_q;
  mem_pkg::word_t        rf [32];

  logic [6:0]            op_field;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  mem_pkg::word_t        imm_i;
  mem_pkg::word_t        imm_s;
  mem_pkg::word_t        imm_b;

  logic                  req_sent;
  logic                  pkt_fire;
  logic                  req_fire;
  logic                  resp_fire;
  logic                  is_mem;
  logic                  rf_wen;
  logic                  br_taken;
  mem_pkg::word_t        alu_b;
  mem_pkg::word_t        alu_sum;
  mem_pkg::word_t        wb_data;

  // ----------------------------------------
  // Decode and operand read
  // ----------------------------------------

  assign op_field = pkt.inst[6:0];
  assign funct3   = pkt.inst[14:12];
  assign funct7   = pkt.inst[31:25];
  assign imm_i    = {{20{pkt.inst[31]}}, pkt.inst[31:20]};
  assign imm_s    = {{20{pkt.inst[31]}}, pkt.inst[31:25], pkt.inst[11:7]};
  assign imm_b    = {{19{pkt.inst[31]}}, pkt.inst[31], pkt.inst[7],
                     pkt.inst[30:25], pkt.inst[11:8], 1'b0};

  always_comb begin
    dec.rd     = pkt.inst[11:7];
    dec.rs1    = pkt.inst[19:15];
    dec.rs2    = pkt.inst[24:20];
    dec.opcode = core_pkg::op_illegal;
    dec.imm    = '0;
    case (op_field)
      7'b0010011: if (funct3 == 3'b000) begin
        dec.opcode = core_pkg::op_addi;
        dec.imm    = imm_i;
      end
      7'b0110011: if (funct3 == 3'b000 && funct7 == 7'b0) begin
        dec.opcode = core_pkg::op_add;
      end
      7'b0000011: if (funct3 == 3'b010) begin
        dec.opcode = core_pkg::op_lw;
        dec.imm    = imm_i;
      end
      7'b0100011: if (funct3 == 3'b010) begin
        dec.opcode = core_pkg::op_sw;
        dec.imm    = imm_s;
      end
      7'b1100011: if (funct3 == 3'b001) begin
        dec.opcode = core_pkg::op_bne;
        dec.imm    = imm_b;
      end
      default: dec.opcode = core_pkg::op_illegal;
    endcase
  end

  // x0 reads as zero
  assign rs1_val = (dec.rs1 == '0) ? '0 : rf[dec.rs1];
  assign rs2_val = (dec.rs2 == '0) ? '0 : rf[dec.rs2];
  assign is_mem  = (dec.opcode == core_pkg::op_lw) || (dec.opcode == core_pkg::op_sw);

  // ----------------------------------------
  // FSM and handshakes
  // ----------------------------------------

  // One instruction at a time, so no forwarding needed
  assign pkt_rdy       = (state == core_pkg::st_idle);
  assign pkt_fire      = pkt_val && pkt_rdy;
  assign dmem_req_val  = (state == core_pkg::st_wait_mem) && !req_sent;
  assign dmem_resp_rdy = (state == core_pkg::st_wait_mem) && req_sent;
  assign req_fire      = dmem_req_val && dmem_req_rdy;
  assign resp_fire     = dmem_resp_val && dmem_resp_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= core_pkg::st_idle;
      req_sent <= 1'b0;
    end else begin
      case (state)
        core_pkg::st_idle: if (pkt_fire) begin
          state    <= is_mem ? core_pkg::st_wait_mem : core_pkg::st_retire;
          req_sent <= 1'b0;
        end
        core_pkg::st_wait_mem: begin
          if (req_fire)
            req_sent <= 1'b1;
          if (resp_fire)
            state <= core_pkg::st_retire;
        end
        core_pkg::st_retire: state <= core_pkg::st_idle;
        default: state <= core_pkg::st_idle;
      endcase
    end
  end

  // Latched instruction, operands, load data, register writes
  always_ff @(posedge clk) begin
    if (pkt_fire) begin
      pc_q  <= pkt.pc;
      dec_q <= dec;
      rs1_q <= rs1_val;
      rs2_q <= rs2_val;
    end
    if (resp_fire)
      ld_data_q <= dmem_resp.data;
    if (rf_wen)
      rf[dec_q.rd] <= wb_data;
  end

  // ----------------------------------------
  // ALU, memory request, retirement
  // ----------------------------------------

  // Shared adder: sum for ADD/ADDI, address for LW/SW
  assign alu_b   = (dec_q.opcode == core_pkg::op_add) ? rs2_q : dec_q.imm;
  assign alu_sum = rs1_q + alu_b;

  // Payload held by the latched registers while waiting
  assign dmem_req = '{
    op:   (dec_q.opcode == core_pkg::op_sw) ? mem_pkg::mem_write : mem_pkg::mem_read,
    opaq: '0,
    addr: alu_sum,
    data: rs2_q
  };

  assign rf_wen = (state == core_pkg::st_retire) && (dec_q.rd != '0) &&
                  ((dec_q.opcode == core_pkg::op_addi) ||
                   (dec_q.opcode == core_pkg::op_add) ||
                   (dec_q.opcode == core_pkg::op_lw));
  assign wb_data = (dec_q.opcode == core_pkg::op_lw) ? ld_data_q : alu_sum;

  // Taken branch redirects in its retire cycle
  assign br_taken        = (dec_q.opcode == core_pkg::op_bne) && (rs1_q != rs2_q);
  assign redirect.val    = (state == core_pkg::st_retire) && br_taken;
  assign redirect.target = pc_q + dec_q.imm;

  assign trace_val   = (state == core_pkg::st_retire);
  assign trace.pc    = pc_q;
  assign trace.wen   = rf_wen;
  assign trace.waddr = rf_wen ? dec_q.rd : '0;
  assign trace.wdata = rf_wen ? wb_data : '0;

  // ----------------------------------------
  // Assertions
  // ----------------------------------------

  a_resp_in_wait: assert property (@(posedge clk) disable iff (reset)
    dmem_resp_val |-> state == core_pkg::st_wait_mem)
    else $error("exec: data response outside wait_mem");

  a_no_x0_write: assert property (@(posedge clk) disable iff (reset)
    trace_val && trace.wen |-> trace.waddr != '0)
    else $error("exec: trace write to x0");

  // Loads and stores must complete in bounded time
  a_mem_timeout: assert property (@(posedge clk) disable iff (reset)
    $rose(state == core_pkg::st_wait_mem) |->
      ##[1:`CORE_MEM_TIMEOUT] state != core_pkg::st_wait_mem)
    else $error("exec: stuck in wait_mem");

endmodule

`default_nettype wire

/* core_top.sv */
// Core top
// Fetch and execute joined to the instruction, data and trace ports

`default_nettype none

module core_top (
  input  logic                  clk,
  input  logic                  reset,
  output mem_pkg::mem_req_t     imem_req,
  output logic                  imem_req_val,
  input  logic                  imem_req_rdy,
  input  mem_pkg::mem_resp_t    imem_resp,
  input  logic                  imem_resp_val,
  output logic                  imem_resp_rdy,
  output mem_pkg::mem_req_t     dmem_req,
  output logic                  dmem_req_val,
  input  logic                  dmem_req_rdy,
  input  mem_pkg::mem_resp_t    dmem_resp,
  input  logic                  dmem_resp_val,
  output logic                  dmem_resp_rdy,
  output core_pkg::inst_trace_t trace,
  output logic                  trace_val
);

  // Fetch to execute
  core_pkg::fetch_pkt_t pkt;
  logic                 pkt_val;
  logic                 pkt_rdy;
  // Execute back to fetch
  core_pkg::redirect_t  redirect;

  fetch_unit fetch0 (
    .clk,
    .reset,
    .imem_req,
    .imem_req_val,
    .imem_req_rdy,
    .imem_resp,
    .imem_resp_val,
    .imem_resp_rdy,
    .redirect,
    .pkt,
    .pkt_val,
    .pkt_rdy
  );

  exec_unit exec0 (
    .clk,
    .reset,
    .pkt,
    .pkt_val,
    .pkt_rdy,
    .dmem_req,
    .dmem_req_val,
    .dmem_req_rdy,
    .dmem_resp,
    .dmem_resp_val,
    .dmem_resp_rdy,
    .redirect,
    .trace,
    .trace_val
  );

endmodule

`default_nettype wire

/* tb_mem_server.sv */
// Test memory for the core
// One word array behind an instruction port and a data port, with
// random response delay of 0 to 3 cycles and random request back-pressure

`default_nettype none

module tb_mem_server (
  input  logic               clk,
  input  logic               reset,
  input  mem_pkg::mem_req_t  imem_req,
  input  logic               imem_req_val,
  output logic               imem_req_rdy,
  output mem_pkg::mem_resp_t imem_resp,
  output logic               imem_resp_val,
  input  logic               imem_resp_rdy,
  input  mem_pkg::mem_req_t  dmem_req,
  input  logic               dmem_req_val,
  output logic               dmem_req_rdy,
  output mem_pkg::mem_resp_t dmem_resp,
  output logic               dmem_resp_val,
  input  logic               dmem_resp_rdy
);

  // 4 KB of words, index is addr[11:2]
  mem_pkg::word_t     mem [1024];

  // Port 0 is instruction, port 1 is data
  mem_pkg::mem_req_t  req [2];
  logic               req_val [2];
  logic               req_rdy [2];
  mem_pkg::mem_resp_t resp [2];
  logic               resp_val [2];
  logic               resp_rdy [2];

  // Pending responses per port, small ring kept in order
  mem_pkg::mem_resp_t pend [2][4];
  int                 due [2][4];
  int                 rd_ptr [2];
  int                 wr_ptr [2];
  int                 count [2];
  int                 cycle;
  int                 seed = 32'h9e62;

  assign req[0]        = imem_req;
  assign req[1]        = dmem_req;
  assign req_val[0]    = imem_req_val;
  assign req_val[1]    = dmem_req_val;
  assign resp_rdy[0]   = imem_resp_rdy;
  assign resp_rdy[1]   = dmem_resp_rdy;
  assign imem_req_rdy  = req_rdy[0];
  assign dmem_req_rdy  = req_rdy[1];
  assign imem_resp     = resp[0];
  assign dmem_resp     = resp[1];
  assign imem_resp_val = resp_val[0];
  assign dmem_resp_val = resp_val[1];

  initial begin
    cycle = 0;
    for (int p = 0; p < 2; p++) begin
      req_rdy[p]  = 1'b0;
      resp_val[p] = 1'b0;
      resp[p]     = '0;
      rd_ptr[p]   = 0;
      wr_ptr[p]   = 0;
      count[p]    = 0;
    end
  end

  // Backdoor access for program and data loading
  task automatic clear_all();
    for (int i = 0; i < 1024; i++)
      mem[i] = '0;
  endtask

  task automatic write_word(input int idx, input mem_pkg::word_t data);
    mem[idx] = data;
  endtask

  // ----------------------------------------
  // Handshakes at the edge, new outputs 2 units later
  // ----------------------------------------

  always @(posedge clk) begin
    mem_pkg::mem_resp_t r;
    logic               in_reset;
    in_reset = reset;
    cycle    = cycle + 1;
    for (int p = 0; p < 2; p++) begin
      if (in_reset) begin
        rd_ptr[p] = 0;
        wr_ptr[p] = 0;
        count[p]  = 0;
      end else begin
        if (resp_val[p] && resp_rdy[p]) begin
          rd_ptr[p] = (rd_ptr[p] + 1) % 4;
          count[p]  = count[p] - 1;
        end
        if (req_val[p] && req_rdy[p]) begin
          if (req[p].op == mem_pkg::mem_write)
            mem[req[p].addr[11:2]] = req[p].data;
          // Tag echoed unchanged, write returns the stored word
          r.op   = req[p].op;
          r.opaq = req[p].opaq;
          r.data = mem[req[p].addr[11:2]];
          pend[p][wr_ptr[p]] = r;
          due[p][wr_ptr[p]]  = cycle + ($random(seed) & 3);
          wr_ptr[p] = (wr_ptr[p] + 1) % 4;
          count[p]  = count[p] + 1;
        end
      end
    end
    #2;
    for (int p = 0; p < 2; p++) begin
      // Ready low about one cycle in four
      req_rdy[p]  = !in_reset && (($random(seed) & 3) != 0);
      resp_val[p] = !in_reset && (count[p] > 0) && (due[p][rd_ptr[p]] <= cycle);
      resp[p]     = pend[p][rd_ptr[p]];
    end
  end

endmodule

`default_nettype wire

/* tb_core.sv */
// Core testbench
// Loads small programs, runs an ISA-level golden model next to the core
// and checks trace records and data requests with concurrent assertions

`default_nettype none

`include "core_params.svh"

module tb_core;

  logic                  clk;
  logic                  reset;
  mem_pkg::mem_req_t     imem_req;
  logic                  imem_req_val;
  logic                  imem_req_rdy;
  mem_pkg::mem_resp_t    imem_resp;
  logic                  imem_resp_val;
  logic                  imem_resp_rdy;
  mem_pkg::mem_req_t     dmem_req;
  logic                  dmem_req_val;
  logic                  dmem_req_rdy;
  mem_pkg::mem_resp_t    dmem_resp;
  logic                  dmem_resp_val;
  logic                  dmem_resp_rdy;
  core_pkg::inst_trace_t trace;
  logic                  trace_val;

  // Golden memory image and expected streams
  mem_pkg::word_t        img [1024];
  core_pkg::inst_trace_t exp_q [$];
  mem_pkg::mem_req_t     dexp_q [$];
  core_pkg::inst_trace_t exp_head;
  mem_pkg::mem_req_t     dexp_head;
  int                    exp_left;
  int                    dexp_left;
  logic                  trace_took;
  logic                  dmem_took;
  int                    load_idx;
  int                    errors;
  int                    traces;
  int                    tests_run;
  int                    tests_failed;

  core_top dut0 (
    .clk,
    .reset,
    .imem_req,
    .imem_req_val,
    .imem_req_rdy,
    .imem_resp,
    .imem_resp_val,
    .imem_resp_rdy,
    .dmem_req,
    .dmem_req_val,
    .dmem_req_rdy,
    .dmem_resp,
    .dmem_resp_val,
    .dmem_resp_rdy,
    .trace,
    .trace_val
  );

  tb_mem_server mem0 (
    .clk,
    .reset,
    .imem_req,
    .imem_req_val,
    .imem_req_rdy,
    .imem_resp,
    .imem_resp_val,
    .imem_resp_rdy,
    .dmem_req,
    .dmem_req_val,
    .dmem_req_rdy,
    .dmem_resp,
    .dmem_resp_val,
    .dmem_resp_rdy
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ----------------------------------------
  // Instruction encoders
  // ----------------------------------------

  function automatic mem_pkg::word_t addi_w(input core_pkg::reg_idx_t rd,
                                            input core_pkg::reg_idx_t rs1,
                                            input logic [31:0] imm);
    return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic mem_pkg::word_t add_w(input core_pkg::reg_idx_t rd,
                                           input core_pkg::reg_idx_t rs1,
                                           input core_pkg::reg_idx_t rs2);
    return {7'b0, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  function automatic mem_pkg::word_t lw_w(input core_pkg::reg_idx_t rd,
                                          input core_pkg::reg_idx_t rs1,
                                          input logic [31:0] imm);
    return {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
  endfunction

  // S-type, immediate split around rs2/rs1
  function automatic mem_pkg::word_t sw_w(input core_pkg::reg_idx_t rs2,
                                          input core_pkg::reg_idx_t rs1,
                                          input logic [31:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  // B-type, byte offset with bit 0 implied
  function automatic mem_pkg::word_t bne_w(input core_pkg::reg_idx_t rs1,
                                           input core_pkg::reg_idx_t rs2,
                                           input logic [31:0] off);
    return {off[12], off[10:5], rs2, rs1, 3'b001, off[4:1], off[11], 7'b1100011};
  endfunction

  // ----------------------------------------
  // Golden model
  // ----------------------------------------

  task automatic run_golden(input int steps);
    mem_pkg::word_t        regs [32];
    mem_pkg::word_t        iw;
    mem_pkg::word_t        a;
    mem_pkg::word_t        b;
    mem_pkg::word_t        res;
    mem_pkg::addr_t        pc;
    mem_pkg::addr_t        npc;
    mem_pkg::addr_t        ea;
    logic                  wr;
    core_pkg::inst_trace_t rec;
    mem_pkg::mem_req_t     dr;
    for (int i = 0; i < 32; i++)
      regs[i] = '0;
    pc = `CORE_RESET_PC;
    for (int s = 0; s < steps; s++) begin
      iw      = img[pc[11:2]];
      a       = regs[iw[19:15]];
      b       = regs[iw[24:20]];
      npc     = pc + 32'd4;
      wr      = 1'b0;
      res     = '0;
      dr.opaq = '0;
      dr.data = '0;
      // Match on funct3 and major opcode
      case ({iw[14:12], iw[6:0]})
        10'b000_0010011: begin
          res = a + {{20{iw[31]}}, iw[31:20]};
          wr  = 1'b1;
        end
        10'b000_0110011: if (iw[31:25] == 7'd0) begin
          res = a + b;
          wr  = 1'b1;
        end
        10'b010_0000011: begin
          ea      = a + {{20{iw[31]}}, iw[31:20]};
          res     = img[ea[11:2]];
          wr      = 1'b1;
          dr.op   = mem_pkg::mem_read;
          dr.addr = ea;
          dexp_q.push_back(dr);
        end
        10'b010_0100011: begin
          ea             = a + {{20{iw[31]}}, iw[31:25], iw[11:7]};
          img[ea[11:2]]  = b;
          dr.op          = mem_pkg::mem_write;
          dr.addr        = ea;
          dr.data        = b;
          dexp_q.push_back(dr);
        end
        10'b001_1100011: if (a != b)
          npc = pc + {{19{iw[31]}}, iw[31], iw[7], iw[30:25], iw[11:8], 1'b0};
        // Anything else retires as a no-op
        default: ;
      endcase
      rec.pc    = pc;
      rec.waddr = '0;
      rec.wdata = '0;
      rec.wen   = 1'b0;
      // x0 is never written and shows wen low
      if (wr && iw[11:7] != 5'd0) begin
        regs[iw[11:7]] = res;
        rec.waddr      = iw[11:7];
        rec.wdata      = res;
        rec.wen        = 1'b1;
      end
      exp_q.push_back(rec);
      pc = npc;
    end
  endtask

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  task automatic log_mismatch(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    errors++;
    $display("error t=%0t %s expected %h actual %h", $time, name, expected, actual);
  endtask

  task automatic fail_check(input string msg);
    errors++;
    $display("failure t=%0t %s", $time, msg);
  endtask

  a_reset_quiet: assert property (@(posedge clk)
    reset |=> !imem_req_val && !dmem_req_val && !trace_val)
    else fail_check("request or trace valid in the cycle after reset");

  a_first_fetch: assert property (@(posedge clk)
    $fell(reset) |=> imem_req_val && imem_req.addr == `CORE_RESET_PC)
    else fail_check("first instruction request missing or not at the reset PC");

  a_trace_pc: assert property (@(posedge clk) disable iff (reset)
    trace_val && exp_left > 0 |-> trace.pc == exp_head.pc)
    else log_mismatch("trace.pc", exp_head.pc, $sampled(trace.pc));

  a_trace_wen: assert property (@(posedge clk) disable iff (reset)
    trace_val && exp_left > 0 |-> trace.wen == exp_head.wen)
    else log_mismatch("trace.wen", exp_head.wen, $sampled(trace.wen));

  a_trace_waddr: assert property (@(posedge clk) disable iff (reset)
    trace_val && exp_left > 0 |-> trace.waddr == exp_head.waddr)
    else log_mismatch("trace.waddr", exp_head.waddr, $sampled(trace.waddr));

  a_trace_wdata: assert property (@(posedge clk) disable iff (reset)
    trace_val && exp_left > 0 |-> trace.wdata == exp_head.wdata)
    else log_mismatch("trace.wdata", exp_head.wdata, $sampled(trace.wdata));

  a_dmem_expected: assert property (@(posedge clk) disable iff (reset)
    dmem_req_val && dmem_req_rdy |-> dexp_left > 0)
    else fail_check("data request that the golden model does not predict");

  a_dmem_op: assert property (@(posedge clk) disable iff (reset)
    dmem_req_val && dmem_req_rdy && dexp_left > 0 |-> dmem_req.op == dexp_head.op)
    else log_mismatch("dmem_req.op", dexp_head.op, $sampled(dmem_req.op));

  a_dmem_addr: assert property (@(posedge clk) disable iff (reset)
    dmem_req_val && dmem_req_rdy && dexp_left > 0 |-> dmem_req.addr == dexp_head.addr)
    else log_mismatch("dmem_req.addr", dexp_head.addr, $sampled(dmem_req.addr));

  // Store data only, load data field is unused
  a_dmem_data: assert property (@(posedge clk) disable iff (reset)
    dmem_req_val && dmem_req_rdy && dexp_left > 0 && dexp_head.op == mem_pkg::mem_write
    |-> dmem_req.data == dexp_head.data)
    else log_mismatch("dmem_req.data", dexp_head.data, $sampled(dmem_req.data));

  // Data request held under back-pressure
  a_dmem_hold: assert property (@(posedge clk) disable iff (reset)
    dmem_req_val && !dmem_req_rdy |=> dmem_req_val && $stable(dmem_req))
    else fail_check("data request dropped or changed under back-pressure");

  // Responses arrive only for accepted requests, so each one is taken
  a_imem_resp_taken: assert property (@(posedge clk) disable iff (reset)
    imem_resp_val |-> imem_resp_rdy)
    else fail_check("instruction response offered but not accepted");

  a_dmem_resp_taken: assert property (@(posedge clk) disable iff (reset)
    dmem_resp_val |-> dmem_resp_rdy)
    else fail_check("data response offered but not accepted");

  // Transfers seen at the edge, queues popped at the falling edge
  always @(posedge clk) begin
    trace_took <= trace_val && !reset;
    dmem_took  <= dmem_req_val && dmem_req_rdy && !reset;
  end

  always @(negedge clk) begin
    if (trace_took && exp_q.size() > 0) begin
      void'(exp_q.pop_front());
      traces++;
    end
    if (dmem_took && dexp_q.size() > 0)
      void'(dexp_q.pop_front());
    exp_left  = exp_q.size();
    dexp_left = dexp_q.size();
    if (exp_left > 0)
      exp_head = exp_q[0];
    if (dexp_left > 0)
      dexp_head = dexp_q[0];
  end

  // ----------------------------------------
  // Test sequencing
  // ----------------------------------------

  // Reset on, memories cleared, program loads from the reset PC
  task automatic start_test();
    @(posedge clk);
    #2;
    reset = 1'b1;
    @(posedge clk);
    #2;
    mem0.clear_all();
    for (int i = 0; i < 1024; i++)
      img[i] = '0;
    exp_q.delete();
    dexp_q.delete();
    load_idx = `CORE_RESET_PC >> 2;
  endtask

  task automatic emit(input mem_pkg::word_t w);
    img[load_idx] = w;
    mem0.write_word(load_idx, w);
    load_idx++;
  endtask

  task automatic finish_test(input string name, input int steps);
    int err0;
    int trace0;
    int wait_cycles;
    run_golden(steps);
    err0 = errors;
    // Five reset edges in all
    repeat (4) @(posedge clk);
    #2;
    reset       = 1'b0;
    trace0      = traces;
    wait_cycles = 0;
    while (exp_q.size() > 0 && wait_cycles < 2000) begin
      @(posedge clk);
      wait_cycles++;
    end
    if (exp_q.size() > 0)
      fail_check($sformatf("%s timed out with %0d traces outstanding", name, exp_q.size()));
    if (dexp_q.size() > 0)
      fail_check($sformatf("%s ended with %0d data requests missing", name, dexp_q.size()));
    tests_run++;
    if (errors != err0)
      tests_failed++;
    $display("test %-16s %s, %0d traces, %0d errors", name,
             (errors == err0) ? "passed" : "failed", traces - trace0, errors - err0);
  endtask

  initial begin
    reset        = 1'b1;
    errors       = 0;
    traces       = 0;
    tests_run    = 0;
    tests_failed = 0;
    trace_took   = 1'b0;
    dmem_took    = 1'b0;
    exp_left     = 0;
    dexp_left    = 0;
    load_idx     = 0;

    // Reset state and a dependency chain, one write to x0
    start_test();
    emit(addi_w(1, 0, 5));
    emit(addi_w(2, 1, 7));
    emit(add_w(3, 1, 2));
    emit(add_w(3, 3, 3));
    emit(addi_w(0, 1, 1));
    emit(add_w(4, 3, 1));
    emit(addi_w(5, 4, -100));
    finish_test("reset_alu_chain", 7);

    // Store then load of the same word
    start_test();
    emit(addi_w(1, 0, 32'h100));
    emit(addi_w(2, 0, 32'h5a5));
    emit(sw_w(2, 1, 8));
    emit(lw_w(3, 1, 8));
    emit(add_w(4, 3, 2));
    emit(sw_w(4, 0, 32'h200));
    emit(lw_w(5, 0, 32'h200));
    finish_test("store_load", 7);

    // Taken BNE over two words already in the fetch window
    start_test();
    emit(addi_w(1, 0, 1));
    emit(bne_w(1, 0, 12));
    emit(addi_w(2, 0, 99));
    emit(addi_w(3, 0, 98));
    emit(addi_w(4, 1, 3));
    emit(add_w(5, 4, 4));
    finish_test("bne_taken", 4);

    // Not-taken BNE, then four loop passes with a store each pass
    start_test();
    emit(addi_w(1, 0, 4));
    emit(addi_w(2, 0, 0));
    emit(bne_w(1, 1, 8));
    emit(addi_w(2, 2, 3));
    emit(sw_w(2, 0, 32'h180));
    emit(addi_w(1, 1, -1));
    emit(bne_w(1, 0, -12));
    emit(lw_w(5, 0, 32'h180));
    finish_test("bne_loop", 20);

    $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+.
mem_pkg.sv
core_pkg.sv
fetch_unit.sv
exec_unit.sv
core_top.sv
tb_mem_server.sv
tb_core.sv

/* Makefile */
# Verilator build and run of the RV32 core testbench

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert --top-module tb_core \
	  -f filelist.f -Mdir obj_dir -o tb_core
	@out="$$(./obj_dir/tb_core)"; \
	  echo "$$out"; \
	  echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir
